//--- design/dcache_pkg.sv
// ----------------------------------------
// dcache shared definitions
// geometry of the two-way cache, vector types,
// core and miss port structs, controller states
// ----------------------------------------
`default_nettype none

package dcache_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int NUM_WAYS     = 2;
  localparam int NUM_SETS     = 16;
  localparam int WORD_BYTES   = 8;
  // two 64-bit words per line
  localparam int LINE_BYTES   = 16;
  localparam int ADDR_WIDTH   = 20;
  localparam int OFFSET_WIDTH = 4;
  localparam int SET_WIDTH    = 4;
  localparam int TAG_WIDTH    = 12;
  localparam int ID_WIDTH     = 4;

  // response data source, driven by the controller
  localparam logic [1:0] RSRC_HIT    = 2'd0;
  localparam logic [1:0] RSRC_REFILL = 2'd1;
  localparam logic [1:0] RSRC_BYPASS = 2'd2;

  // ----------------------------------------
  // vector types
  // ----------------------------------------
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [TAG_WIDTH-1:0]      tag_t;
  typedef logic [SET_WIDTH-1:0]      set_t;
  typedef logic [OFFSET_WIDTH-1:0]   offset_t;
  typedef logic [8*WORD_BYTES-1:0]   word_t;
  typedef logic [8*LINE_BYTES-1:0]   line_t;
  typedef logic [WORD_BYTES-1:0]     be_t;
  // one-hot, bit n selects way n
  typedef logic [NUM_WAYS-1:0]       way_t;
  typedef logic [ID_WIDTH-1:0]       id_t;

  // ----------------------------------------
  // port structs
  // ----------------------------------------
  typedef struct packed {
    logic  data_req;
    logic  we;
    addr_t addr;
    be_t   be;
    word_t wdata;
    id_t   id;
  } core_req_t;

  typedef struct packed {
    logic  data_gnt;
    logic  data_rvalid;
    word_t rdata;
    id_t   rid;
  } core_resp_t;

  typedef struct packed {
    logic  valid;
    logic  bypass;
    logic  we;
    addr_t addr;
    be_t   be;
    word_t wdata;
  } miss_req_t;

  // request as held by the controller while it is served
  typedef struct packed {
    logic  we;
    addr_t addr;
    be_t   be;
    word_t wdata;
    id_t   id;
    logic  bypass;
  } saved_req_t;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_TAG,
    STORE_REQ,
    WAIT_MISS_GNT,
    WAIT_REFILL,
    WAIT_BYPASS_VALID
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/dcache_req_capture.sv
// ----------------------------------------
// dcache request capture
// holds the accepted core request and the
// bypass level for the whole transaction
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_req_capture (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  dcache_pkg::core_req_t   req_i,
  // pulsed by the controller when it accepts a request
  input  logic                    capture_i,
  input  logic                    bypass_i,
  output dcache_pkg::saved_req_t  saved_o
);

  import dcache_pkg::*;

  saved_req_t saved_q;

  // ----------------------------------------
  // saved request register
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      saved_q <= '0;
    end else if (capture_i) begin
      saved_q.we     <= req_i.we;
      saved_q.addr   <= req_i.addr;
      saved_q.be     <= req_i.be;
      saved_q.wdata  <= req_i.wdata;
      saved_q.id     <= req_i.id;
      // bypass is sampled once, a later change does not
      // affect a request already in flight
      saved_q.bypass <= bypass_i;
    end
  end

  assign saved_o = saved_q;

endmodule

`default_nettype wire

//--- design/dcache_tag_data_array.sv
// ----------------------------------------
// dcache tag and data array
// valid bits, tags and lines of both ways,
// one-cycle lookup with hit compare and
// victim choice, byte-masked line write
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_data_array (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // lookup
  input  logic                               rd_i,
  input  dcache_pkg::set_t                   set_i,
  input  dcache_pkg::tag_t                   tag_i,
  // write
  input  logic                               wr_i,
  input  dcache_pkg::way_t                   wr_way_i,
  input  dcache_pkg::line_t                  wr_line_i,
  input  logic [dcache_pkg::LINE_BYTES-1:0]  wr_be_i,
  input  logic                               fill_i,
  // lookup result, one cycle after rd_i
  output dcache_pkg::way_t                   hit_way_o,
  output dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] lines_o,
  output dcache_pkg::way_t                   victim_way_o
);

  import dcache_pkg::*;

  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
  tag_t                tag_q   [NUM_WAYS][NUM_SETS];
  line_t               data_q  [NUM_WAYS][NUM_SETS];
  // per-set round-robin pointer, names the way replaced next
  logic [NUM_SETS-1:0] rr_q;
  set_t                rd_set_q;

  // ----------------------------------------
  // control state
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_q[w] <= '0;
      end
      rr_q     <= '0;
      rd_set_q <= '0;
    end else begin
      if (rd_i) begin
        rd_set_q <= set_i;
      end
      // a fill makes the line valid and moves the pointer on
      if (wr_i && fill_i) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (wr_way_i[w]) begin
            valid_q[w][set_i] <= 1'b1;
          end
        end
        rr_q[set_i] <= ~rr_q[set_i];
      end
    end
  end

  // ----------------------------------------
  // tags and line data
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (wr_way_i[w]) begin
          if (fill_i) begin
            tag_q[w][set_i] <= tag_i;
          end
          // only enabled bytes change, a store merges one word
          for (int b = 0; b < LINE_BYTES; b++) begin
            if (wr_be_i[b]) begin
              data_q[w][set_i][8*b +: 8] <= wr_line_i[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // ----------------------------------------
  // lookup result for the registered set
  // ----------------------------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      lines_o[w]   = data_q[w][rd_set_q];
      hit_way_o[w] = valid_q[w][rd_set_q] && (tag_q[w][rd_set_q] == tag_i);
    end
  end

  // first invalid way wins, else the round-robin way
  always_comb begin
    victim_way_o = '0;
    victim_way_o[rr_q[rd_set_q]] = 1'b1;
    for (int w = NUM_WAYS-1; w >= 0; w--) begin
      if (!valid_q[w][rd_set_q]) begin
        victim_way_o    = '0;
        victim_way_o[w] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_ctrl_fsm.sv
// ----------------------------------------
// dcache controller
// sequences lookup, store merge, write-through,
// refill and bypass, owns grant and rvalid
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl_fsm (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  dcache_pkg::core_req_t              req_i,
  input  logic                               bypass_i,
  input  dcache_pkg::saved_req_t             saved_i,
  output logic                               capture_o,
  // array control
  output logic                               rd_o,
  output dcache_pkg::set_t                   set_o,
  output dcache_pkg::tag_t                   tag_o,
  output logic                               wr_o,
  output dcache_pkg::way_t                   wr_way_o,
  output dcache_pkg::line_t                  wr_line_o,
  output logic [dcache_pkg::LINE_BYTES-1:0]  wr_be_o,
  output logic                               fill_o,
  input  dcache_pkg::way_t                   hit_way_i,
  input  dcache_pkg::way_t                   victim_way_i,
  // miss unit
  output dcache_pkg::miss_req_t              miss_req_o,
  input  logic                               miss_gnt_i,
  input  logic                               refill_valid_i,
  input  dcache_pkg::line_t                  refill_line_i,
  input  logic                               bypass_valid_i,
  // core strobes
  output logic                               data_gnt_o,
  output logic                               rvalid_o,
  output logic [1:0]                         rsrc_o,
  output logic                               busy_o
);

  import dcache_pkg::*;

  ctrl_state_e state_q, state_d;
  // hit way of a store, victim way of a load miss
  way_t        way_q, way_d;
  // refill written last cycle, critical word due now
  logic        refill_done_q, refill_done_d;

  set_t        saved_set;
  set_t        req_set;
  logic        saved_word;
  logic [LINE_BYTES-1:0] store_be;

  assign saved_set  = saved_i.addr[OFFSET_WIDTH +: SET_WIDTH];
  assign saved_word = saved_i.addr[OFFSET_WIDTH-1];
  assign req_set    = req_i.addr[OFFSET_WIDTH +: SET_WIDTH];
  // compare and fill both use the held tag
  assign tag_o      = saved_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];

  // store byte enable placed on its word of the line
  assign store_be = saved_word ? {saved_i.be, {WORD_BYTES{1'b0}}}
                               : {{WORD_BYTES{1'b0}}, saved_i.be};

  assign busy_o = (state_q != IDLE) || refill_done_q;

  // ----------------------------------------
  // next state and outputs
  // ----------------------------------------
  always_comb begin
    state_d       = state_q;
    way_d         = way_q;
    refill_done_d = 1'b0;
    capture_o     = 1'b0;
    rd_o          = 1'b0;
    set_o         = saved_set;
    wr_o          = 1'b0;
    wr_way_o      = way_q;
    wr_line_o     = {2{saved_i.wdata}};
    wr_be_o       = store_be;
    fill_o        = 1'b0;
    miss_req_o    = '0;
    data_gnt_o    = 1'b0;
    rvalid_o      = 1'b0;
    rsrc_o        = RSRC_HIT;

    unique case (state_q)
      IDLE: begin
        // critical word of the refill just written
        if (refill_done_q) begin
          rvalid_o = 1'b1;
          rsrc_o   = RSRC_REFILL;
        end
        if (req_i.data_req) begin
          capture_o  = 1'b1;
          // loads are granted at once, stores after write-through
          data_gnt_o = !req_i.we;
          if (bypass_i) begin
            state_d = WAIT_MISS_GNT;
          end else begin
            // speculative lookup of the new set
            rd_o    = 1'b1;
            set_o   = req_set;
            state_d = WAIT_TAG;
          end
        end
      end

      WAIT_TAG: begin
        if (|hit_way_i) begin
          if (!saved_i.we) begin
            rvalid_o = 1'b1;
            state_d  = IDLE;
            // chain the next cached load onto this hit
            if (req_i.data_req && !req_i.we && !bypass_i) begin
              capture_o  = 1'b1;
              data_gnt_o = 1'b1;
              rd_o       = 1'b1;
              set_o      = req_set;
              state_d    = WAIT_TAG;
            end
          end else begin
            way_d   = hit_way_i;
            state_d = STORE_REQ;
          end
        end else if (saved_i.we) begin
          // store miss, no allocation so nothing to write
          way_d   = '0;
          state_d = STORE_REQ;
        end else begin
          way_d   = victim_way_i;
          state_d = WAIT_MISS_GNT;
        end
      end

      STORE_REQ: begin
        // merge on a hit, the array is left alone on a miss
        wr_o    = |way_q;
        state_d = WAIT_MISS_GNT;
      end

      WAIT_MISS_GNT: begin
        miss_req_o.valid  = 1'b1;
        miss_req_o.bypass = saved_i.bypass;
        miss_req_o.we     = saved_i.we;
        miss_req_o.addr   = saved_i.addr;
        miss_req_o.be     = saved_i.be;
        miss_req_o.wdata  = saved_i.wdata;
        if (miss_gnt_i) begin
          if (saved_i.we) begin
            // write-through accepted, store is done
            data_gnt_o = 1'b1;
            state_d    = IDLE;
          end else if (saved_i.bypass) begin
            state_d = WAIT_BYPASS_VALID;
          end else begin
            state_d = WAIT_REFILL;
          end
        end
      end

      WAIT_REFILL: begin
        if (refill_valid_i) begin
          // whole line into the victim way
          wr_o          = 1'b1;
          fill_o        = 1'b1;
          wr_line_o     = refill_line_i;
          wr_be_o       = '1;
          refill_done_d = 1'b1;
          state_d       = IDLE;
        end
      end

      WAIT_BYPASS_VALID: begin
        if (bypass_valid_i) begin
          rvalid_o = 1'b1;
          rsrc_o   = RSRC_BYPASS;
          state_d  = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // state registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= IDLE;
      way_q         <= '0;
      refill_done_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      way_q         <= way_d;
      refill_done_q <= refill_done_d;
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_resp_select.sv
// ----------------------------------------
// dcache response select
// way mux and word pick for hits, critical
// word of a refill, bypass word pass-through
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_resp_select (
  input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] lines_i,
  input  dcache_pkg::way_t                             hit_way_i,
  // word bit of the held address
  input  logic                                         word_sel_i,
  // still on the bus the cycle after its valid pulse
  input  dcache_pkg::line_t                            refill_line_i,
  input  dcache_pkg::word_t                            bypass_data_i,
  input  logic [1:0]                                   rsrc_i,
  output dcache_pkg::word_t                            rdata_o
);

  import dcache_pkg::*;

  line_t hit_line;

  function automatic word_t pick_word(line_t line, logic sel);
    return line[sel*$bits(word_t) +: $bits(word_t)];
  endfunction

  // one-hot way mux, no hit gives zero
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_way_i[w]) begin
        hit_line = hit_line | lines_i[w];
      end
    end
  end

  always_comb begin
    case (rsrc_i)
      RSRC_REFILL: rdata_o = pick_word(refill_line_i, word_sel_i);
      RSRC_BYPASS: rdata_o = bypass_data_i;
      default:     rdata_o = pick_word(hit_line, word_sel_i);
    endcase
  end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
// ----------------------------------------
// dcache top
// blocking two-way data cache controller,
// request capture, controller with array,
// response select
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    bypass_i,
  // core port
  input  dcache_pkg::core_req_t   core_req_i,
  output dcache_pkg::core_resp_t  core_resp_o,
  // miss unit port
  output dcache_pkg::miss_req_t   miss_req_o,
  input  logic                    miss_gnt_i,
  input  logic                    refill_valid_i,
  input  dcache_pkg::line_t       refill_line_i,
  input  logic                    bypass_valid_i,
  input  dcache_pkg::word_t       bypass_data_i,
  output logic                    busy_o
);

  import dcache_pkg::*;

  saved_req_t            saved;
  logic                  capture;
  // array control and lookup result
  logic                  rd;
  set_t                  set;
  tag_t                  tag;
  logic                  wr;
  way_t                  wr_way;
  line_t                 wr_line;
  logic [LINE_BYTES-1:0] wr_be;
  logic                  fill;
  way_t                  hit_way;
  line_t [NUM_WAYS-1:0]  lines;
  way_t                  victim_way;
  // response
  logic                  data_gnt;
  logic                  rvalid;
  logic [1:0]            rsrc;
  word_t                 rdata;

  dcache_req_capture u_req_capture (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (core_req_i),
    .capture_i (capture),
    .bypass_i  (bypass_i),
    .saved_o   (saved)
  );

  dcache_ctrl_fsm u_ctrl_fsm (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (core_req_i),
    .bypass_i       (bypass_i),
    .saved_i        (saved),
    .capture_o      (capture),
    .rd_o           (rd),
    .set_o          (set),
    .tag_o          (tag),
    .wr_o           (wr),
    .wr_way_o       (wr_way),
    .wr_line_o      (wr_line),
    .wr_be_o        (wr_be),
    .fill_o         (fill),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .miss_req_o     (miss_req_o),
    .miss_gnt_i     (miss_gnt_i),
    .refill_valid_i (refill_valid_i),
    .refill_line_i  (refill_line_i),
    .bypass_valid_i (bypass_valid_i),
    .data_gnt_o     (data_gnt),
    .rvalid_o       (rvalid),
    .rsrc_o         (rsrc),
    .busy_o         (busy_o)
  );

  dcache_tag_data_array u_array (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rd_i         (rd),
    .set_i        (set),
    .tag_i        (tag),
    .wr_i         (wr),
    .wr_way_i     (wr_way),
    .wr_line_i    (wr_line),
    .wr_be_i      (wr_be),
    .fill_i       (fill),
    .hit_way_o    (hit_way),
    .lines_o      (lines),
    .victim_way_o (victim_way)
  );

  dcache_resp_select u_resp_select (
    .lines_i       (lines),
    .hit_way_i     (hit_way),
    .word_sel_i    (saved.addr[OFFSET_WIDTH-1]),
    .refill_line_i (refill_line_i),
    .bypass_data_i (bypass_data_i),
    .rsrc_i        (rsrc),
    .rdata_o       (rdata)
  );

  // ----------------------------------------
  // core response
  // ----------------------------------------
  assign core_resp_o.data_gnt    = data_gnt;
  assign core_resp_o.data_rvalid = rvalid;
  assign core_resp_o.rdata       = rdata;
  // id of the request being answered
  assign core_resp_o.rid         = saved.id;

endmodule

`default_nettype wire

//--- tb/dcache_miss_unit_model.sv
// ----------------------------------------
// dcache miss unit model
// grants miss requests after a short random
// delay, applies write-through stores to its
// memory image, returns lines and words late
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_unit_model #(
  parameter logic [31:0] SEED = 32'd1
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  dcache_pkg::miss_req_t  miss_req_i,
  output logic                   miss_gnt_o,
  output logic                   refill_valid_o,
  output dcache_pkg::line_t      refill_line_o,
  output logic                   bypass_valid_o,
  output dcache_pkg::word_t      bypass_data_o,
  // last granted request for the store checks
  output dcache_pkg::miss_req_t  last_req_o,
  output int                     refill_count_o
);

  import dcache_pkg::*;

  // one word per 8-byte address
  localparam int MEM_WORDS = 2 ** (ADDR_WIDTH - 3);

  word_t       mem [MEM_WORDS];
  logic [31:0] rnd;
  miss_req_t   req;
  int          wait_cycles;
  int          idx;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    miss_gnt_o     = 1'b0;
    refill_valid_o = 1'b0;
    refill_line_o  = '0;
    bypass_valid_o = 1'b0;
    bypass_data_o  = '0;
    last_req_o     = '0;
    refill_count_o = 0;
    rnd            = SEED;
    // every word differs and the pattern spans the whole address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (word_t'(i) + 64'd1) * 64'h9E37_79B9_7F4A_7C15;
    end
    forever begin
      @(negedge clk_i);
      if (rst_n_i && miss_req_i.valid) begin
        req = miss_req_i;
        idx = int'(req.addr[ADDR_WIDTH-1:3]);
        // grant after 0 to 3 cycles
        rnd = xorshift32(rnd);
        wait_cycles = int'(rnd % 4);
        repeat (wait_cycles) @(negedge clk_i);
        @(posedge clk_i);
        miss_gnt_o <= 1'b1;
        last_req_o <= req;
        if (req.we) begin
          for (int b = 0; b < WORD_BYTES; b++) begin
            if (req.be[b]) begin
              mem[idx][8*b +: 8] = req.wdata[8*b +: 8];
            end
          end
        end else if (!req.bypass) begin
          refill_count_o <= refill_count_o + 1;
        end
        @(posedge clk_i);
        miss_gnt_o <= 1'b0;
        if (!req.we) begin
          // answer 2 to 6 cycles after the grant
          rnd = xorshift32(rnd);
          wait_cycles = 2 + int'(rnd % 5);
          repeat (wait_cycles - 1) @(posedge clk_i);
          if (req.bypass) begin
            bypass_data_o  <= mem[idx];
            bypass_valid_o <= 1'b1;
          end else begin
            // line stays on the bus until the next refill
            refill_line_o  <= {mem[idx | 1], mem[idx & ~1]};
            refill_valid_o <= 1'b1;
          end
          @(posedge clk_i);
          bypass_valid_o <= 1'b0;
          refill_valid_o <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/dcache_tb.sv
// ----------------------------------------
// dcache testbench
// table of loads and stores applied to the
// cache, answers checked against the memory
// image, refills against a tag model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  import dcache_pkg::*;

  localparam logic [31:0] SEED          = 32'd19067;
  localparam int          RAND_ENTRIES  = 200;
  localparam int          GNT_TIMEOUT   = 40;
  localparam int          DRAIN_TIMEOUT = 60;
  localparam tag_t        RAND_TAG_BASE = 12'h0A0;

  // one row of the stimulus table
  typedef struct packed {
    logic  we;
    logic  bypass;
    // drain the cache and check refills after this row
    logic  sync;
    addr_t addr;
    be_t   be;
    word_t wdata;
    id_t   id;
  } entry_t;

  typedef struct packed {
    word_t data;
    id_t   id;
  } resp_exp_t;

  logic       clk;
  logic       rst_n;
  logic       bypass;
  core_req_t  core_req;
  core_resp_t core_resp;
  miss_req_t  miss_req;
  logic       miss_gnt;
  logic       refill_valid;
  line_t      refill_line;
  logic       bypass_valid;
  word_t      bypass_data;
  logic       busy;
  miss_req_t  last_req;
  int         refill_count;

  entry_t      stim_q [$];
  resp_exp_t   exp_q [$];
  resp_exp_t   exp_item;
  logic [31:0] rng_state;
  // tag model of the cache
  logic        mdl_valid [NUM_WAYS][NUM_SETS];
  tag_t        mdl_tag [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] mdl_rr;
  int          exp_refills;

  dcache_top dut0 (
    .clk_i (clk), .rst_n_i (rst_n), .bypass_i (bypass),
    .core_req_i (core_req), .core_resp_o (core_resp),
    .miss_req_o (miss_req), .miss_gnt_i (miss_gnt),
    .refill_valid_i (refill_valid), .refill_line_i (refill_line),
    .bypass_valid_i (bypass_valid), .bypass_data_i (bypass_data),
    .busy_o (busy)
  );

  dcache_miss_unit_model #(.SEED(SEED ^ 32'h5555)) mu0 (
    .clk_i (clk), .rst_n_i (rst_n), .miss_req_i (miss_req),
    .miss_gnt_o (miss_gnt), .refill_valid_o (refill_valid),
    .refill_line_o (refill_line), .bypass_valid_o (bypass_valid),
    .bypass_data_o (bypass_data), .last_req_o (last_req),
    .refill_count_o (refill_count)
  );

  always #4 clk = ~clk;

  // ----------------------------------------
  // failure reporting and compares
  // ----------------------------------------
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR time %0t: %s got %h expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_id(input id_t got, input id_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR time %0t: rid got %0d expected %0d",
                                  $time, got, exp));
    end
  endtask

  task automatic check_miss_req(input miss_req_t got, input miss_req_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR time %0t: miss request got %h expected %h",
                                  $time, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("ERROR time %0t: refill requests got %0d expected %0d",
                                  $time, got, exp));
    end
  endtask

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic addr_t make_addr(input tag_t t, input set_t s, input logic w);
    return {t, s, w, 3'b000};
  endfunction

  task automatic add_entry(input logic we, input logic byp, input logic sync,
                           input addr_t addr, input be_t be, input word_t wdata,
                           input id_t id);
    entry_t e;
    e.we     = we;
    e.bypass = byp;
    e.sync   = sync;
    e.addr   = addr;
    e.be     = be;
    e.wdata  = wdata;
    e.id     = id;
    stim_q.push_back(e);
  endtask

  task automatic add_directed_entries();
    // load miss, then repeats to the same line
    add_entry(0, 0, 1, make_addr(12'h100, 4'd1, 1'b1), '0, '0, 4'd1);
    add_entry(0, 0, 1, make_addr(12'h100, 4'd1, 1'b1), '0, '0, 4'd2);
    add_entry(0, 0, 1, make_addr(12'h100, 4'd1, 1'b0), '0, '0, 4'd3);
    // fill set 2, then two hits back to back
    add_entry(0, 0, 1, make_addr(12'h100, 4'd2, 1'b0), '0, '0, 4'd4);
    add_entry(0, 0, 0, make_addr(12'h100, 4'd1, 1'b0), '0, '0, 4'd5);
    add_entry(0, 0, 1, make_addr(12'h100, 4'd2, 1'b1), '0, '0, 4'd6);
    // store hit, load sees merged bytes
    add_entry(1, 0, 0, make_addr(12'h100, 4'd1, 1'b1), 8'h0F,
              64'h1122_3344_5566_7788, 4'd7);
    add_entry(0, 0, 1, make_addr(12'h100, 4'd1, 1'b1), '0, '0, 4'd8);
    // store miss goes to memory only
    add_entry(1, 0, 1, make_addr(12'h200, 4'd3, 1'b0), 8'hF0,
              64'hA1B2_C3D4_E5F6_0718, 4'd9);
    add_entry(0, 0, 1, make_addr(12'h200, 4'd3, 1'b0), '0, '0, 4'd10);
    // bypass region, never cached
    add_entry(0, 1, 0, make_addr(12'hB00, 4'd4, 1'b0), '0, '0, 4'd11);
    add_entry(1, 1, 0, make_addr(12'hB00, 4'd4, 1'b0), 8'h3C,
              64'hDEAD_BEEF_CAFE_F00D, 4'd12);
    add_entry(0, 1, 1, make_addr(12'hB00, 4'd4, 1'b0), '0, '0, 4'd13);
  endtask

  task automatic add_random_entries();
    logic [31:0] r;
    logic [31:0] hi;
    tag_t        t;
    for (int i = 0; i < RAND_ENTRIES; i++) begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      rng_state = xorshift(rng_state);
      hi = rng_state;
      rng_state = xorshift(rng_state);
      // three tags compete for the two ways of each set
      t = RAND_TAG_BASE + tag_t'(r % 3);
      add_entry(r[9], 1'b0, (i % 40 == 39), make_addr(t, r[7:4], r[8]), r[23:16],
                {hi, rng_state}, id_t'(i));
    end
  endtask

  // ----------------------------------------
  // tag model: refill on a cached load miss
  // ----------------------------------------
  task automatic predict_load(input addr_t a);
    set_t s;
    tag_t t;
    logic hit;
    int   victim;
    s = a[OFFSET_WIDTH +: SET_WIDTH];
    t = a[ADDR_WIDTH-1 -: TAG_WIDTH];
    hit = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (mdl_valid[w][s] && mdl_tag[w][s] == t) begin
        hit = 1'b1;
      end
    end
    if (!hit) begin
      exp_refills++;
      // lowest invalid way, else the round-robin way
      victim = int'(mdl_rr[s]);
      for (int w = NUM_WAYS-1; w >= 0; w--) begin
        if (!mdl_valid[w][s]) begin
          victim = w;
        end
      end
      mdl_valid[victim][s] = 1'b1;
      mdl_tag[victim][s]   = t;
      mdl_rr[s]            = ~mdl_rr[s];
    end
  endtask

  // ----------------------------------------
  // driver and read answer monitor
  // ----------------------------------------
  task automatic issue(input entry_t e);
    core_req_t req;
    miss_req_t exp_miss;
    resp_exp_t exp;
    int        waited;
    req.data_req = 1'b1;
    req.we       = e.we;
    req.addr     = e.addr;
    req.be       = e.be;
    req.wdata    = e.wdata;
    req.id       = e.id;
    @(posedge clk);
    core_req <= req;
    bypass   <= e.bypass;
    waited = 0;
    @(negedge clk);
    while (!core_resp.data_gnt) begin
      waited++;
      if (waited > GNT_TIMEOUT) begin
        stop_with_failure($sformatf("request id %0d was not granted in %0d cycles",
                                    e.id, GNT_TIMEOUT));
      end
      @(negedge clk);
    end
    if (e.we) begin
      // write-through must carry the store unchanged
      exp_miss.valid  = 1'b1;
      exp_miss.bypass = e.bypass;
      exp_miss.we     = 1'b1;
      exp_miss.addr   = e.addr;
      exp_miss.be     = e.be;
      exp_miss.wdata  = e.wdata;
      check_miss_req(last_req, exp_miss);
    end else begin
      exp.data = mu0.mem[e.addr[ADDR_WIDTH-1:3]];
      exp.id   = e.id;
      exp_q.push_back(exp);
      if (!e.bypass) begin
        predict_load(e.addr);
      end
    end
  endtask

  task automatic drain_and_check();
    int waited;
    @(posedge clk);
    core_req.data_req <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0 || busy) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        stop_with_failure("cache did not go idle with all loads answered");
      end
      @(negedge clk);
    end
    check_count(refill_count, exp_refills);
  endtask

  always @(negedge clk) begin
    if (rst_n && core_resp.data_rvalid) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("read answer arrived with no load outstanding");
      end else begin
        exp_item = exp_q.pop_front();
        check_word(core_resp.rdata, exp_item.data, "rdata");
        check_id(core_resp.rid, exp_item.id);
      end
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    bypass      = 1'b0;
    core_req    = '0;
    rng_state   = SEED;
    exp_refills = 0;
    mdl_rr      = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        mdl_valid[w][s] = 1'b0;
        mdl_tag[w][s]   = '0;
      end
    end
    add_directed_entries();
    add_random_entries();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (core_resp.data_gnt || core_resp.data_rvalid || miss_req.valid || busy) begin
      stop_with_failure("outputs were not idle after reset");
    end
    foreach (stim_q[i]) begin
      issue(stim_q[i]);
      if (stim_q[i].sync) begin
        drain_and_check();
      end
    end
    drain_and_check();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
design/dcache_pkg.sv
design/dcache_req_capture.sv
design/dcache_tag_data_array.sv
design/dcache_ctrl_fsm.sv
design/dcache_resp_select.sv
design/dcache_top.sv
tb/dcache_miss_unit_model.sv
tb/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the dcache testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal --top-module dcache_tb \
    -f src.f -o dcache_sim &&
  ./obj_dir/dcache_sim ||
  { echo "dcache simulation failed"; exit 1; }
